// File: build.f
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/inst_decoder.sv
hw/regfile.sv
hw/exec_unit.sv
hw/lsu.sv
hw/bus_arbiter.sv
hw/cpu_top.sv
dv/tb_mem_model.sv
dv/tb_top.sv

// File: dv/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model (
    input  logic                inst_selfdefine,
    input  logic                reset,
    input  logic                mem_req_valid,
    output logic                mem_req_ready,
    input  cpu_pkg::mem_req_t   mem_req,
    output logic                mem_rsp_valid,
    output cpu_pkg::mem_rsp_t   mem_rsp,
    input  int                  stall_pct,
    input  int                  max_delay
);

    // 4 KB of words indexed by byte address bits 11:2
    logic [31:0] mem [1024];

    integer            seed = 51275;
    logic              req_seen = 1'b0;
    logic              reset_seen = 1'b1;
    int                stall_seen;
    int                delay_seen;
    cpu_pkg::mem_req_t req_cap;
    logic              pending;
    logic [31:0]       rsp_data;
    int                wait_cnt;

    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        pending       = 1'b0;
        wait_cnt      = 0;
        rsp_data      = '0;
        stall_seen    = 0;
        delay_seen    = 0;
    end

    // request channel and controls sampled mid-cycle
    always @(negedge inst_selfdefine) begin
        req_seen   = mem_req_valid;
        req_cap    = mem_req;
        reset_seen = reset;
        stall_seen = stall_pct;
        delay_seen = max_delay;
    end

    always @(posedge inst_selfdefine) begin
        #1;
        mem_rsp_valid = 1'b0;
        if (reset_seen) begin
            pending       = 1'b0;
            mem_req_ready = 1'b0;
        end else begin
            // transfer happened at the edge just passed
            if (!pending && req_seen && mem_req_ready) begin
                if (req_cap.we) begin
                    mem[req_cap.addr[11:2]] = req_cap.wdata;
                end
                rsp_data = mem[req_cap.addr[11:2]];
                pending  = 1'b1;
                wait_cnt = $unsigned($random(seed)) % (delay_seen + 1);
            end
            if (pending) begin
                if (wait_cnt == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp.rdata = rsp_data;
                    pending       = 1'b0;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end
            mem_req_ready = !pending && ($unsigned($random(seed)) % 100 >= stall_seen);
        end
    end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/1ns

module tb_top;

    // base 0x400 plus offset 0x3f0
    localparam logic [31:0] done_addr  = 32'h0000_07f0;
    localparam int          max_stores = 64;

    logic              inst_selfdefine;
    logic              reset;
    logic              mem_req_valid;
    logic              mem_req_ready;
    cpu_pkg::mem_req_t mem_req;
    logic              mem_rsp_valid;
    cpu_pkg::mem_rsp_t mem_rsp;
    int                stall_pct;
    int                max_delay;

    logic [31:0] ref_mem [1024];
    logic [31:0] exp_addr [max_stores];
    logic [31:0] exp_data [max_stores];
    int          exp_count;
    int          got_count;
    int          error_count;
    int          check_count;
    int          prog_len;
    int          budget;
    int          cycles;
    logic        running;
    logic        done_seen;
    string       test_name;

    cpu_top u_dut (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req         (mem_req),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp         (mem_rsp)
    );

    tb_mem_model u_mem (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req         (mem_req),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp         (mem_rsp),
        .stall_pct       (stall_pct),
        .max_delay       (max_delay)
    );

    initial begin
        inst_selfdefine = 1'b0;
        forever #5 inst_selfdefine = ~inst_selfdefine;
    end

    // instruction encoders
    function automatic logic [31:0] add(input int rd, input int rs1, input int rs2);
        return {7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction
    function automatic logic [31:0] sub(input int rd, input int rs1, input int rs2);
        return {7'b0100000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
    endfunction
    function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction
    function automatic logic [31:0] lui(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction
    function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction
    function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction
    function automatic logic [31:0] beq(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction
    function automatic logic [31:0] bne(input int rs1, input int rs2, input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b001, off[4:1], off[11], 7'b1100011};
    endfunction
    function automatic logic [31:0] jal(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    // ISA model, steps until the done store and lists every store on the way
    function automatic int reference_run();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        logic [31:0] addr;
        logic [31:0] next;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc        = cpu_pkg::pc_reset;
        exp_count = 0;
        for (steps = 1; steps <= 500; steps++) begin
            ins  = ref_mem[pc[11:2]];
            a    = regs[ins[19:15]];
            b    = regs[ins[24:20]];
            next = pc + 4;
            wr   = 1'b1;
            val  = '0;
            case (ins[6:0])
                7'b0110011: val = ins[30] ? a - b : a + b;
                7'b0010011: val = a + {{20{ins[31]}}, ins[31:20]};
                7'b0110111: val = {ins[31:12], 12'b0};
                7'b0000011: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    val  = ref_mem[addr[11:2]];
                end
                7'b0100011: begin
                    wr   = 1'b0;
                    addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    ref_mem[addr[11:2]]  = b;
                    exp_addr[exp_count] = addr;
                    exp_data[exp_count] = b;
                    exp_count++;
                    if (addr == done_addr) begin
                        return steps;
                    end
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if ((a == b) != ins[12]) begin
                        next = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                    end
                end
                7'b1101111: begin
                    val  = pc + 4;
                    next = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = val;
            end
            pc = next;
        end
        return steps;
    endfunction

    task automatic compare_word(input string what, input logic [31:0] exp,
                                input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            $display("FAILED %s: expected %h, actual %h", what, exp, act);
            error_count++;
        end
    endtask

    task automatic emit(input logic [31:0] word);
        u_mem.mem[prog_len] = word;
        ref_mem[prog_len]   = word;
        prog_len++;
    endtask

    task automatic fill_memory();
        logic [31:0] addr;
        for (int i = 0; i < 1024; i++) begin
            addr           = i * 4;
            u_mem.mem[i]   = 32'hc3a5_0000 | addr;
            ref_mem[i]     = 32'hc3a5_0000 | addr;
        end
    endtask

    task automatic write_program(input int id);
        // x10 is the data base 0x400
        emit(addi(10, 0, 1024));
        case (id)
            0: begin
                emit(addi(1, 0, 100));
                emit(addi(2, 0, -7));
                emit(add(3, 1, 2));
                emit(sub(4, 2, 1));
                emit(lui(5, 'hfffff));
                emit(lui(6, 'h00001));
                // wraps to zero
                emit(add(7, 5, 6));
                emit(sub(8, 0, 1));
                emit(lui(9, 'h80000));
                emit(addi(9, 9, -1));
                emit(sw(3, 10, 0));
                emit(sw(4, 10, 4));
                emit(sw(5, 10, 8));
                emit(sw(7, 10, 12));
                emit(sw(8, 10, 16));
                emit(sw(9, 10, 20));
            end
            1: begin
                emit(lui(1, 'h12345));
                emit(addi(1, 1, 'h678));
                emit(sw(1, 10, 64));
                emit(lw(2, 10, 64));
                emit(addi(2, 2, 1));
                emit(sw(2, 10, 68));
                // untouched word, fill pattern
                emit(lw(3, 10, 72));
                emit(sw(3, 10, 76));
            end
            2: begin
                emit(addi(1, 0, 5));
                emit(addi(2, 0, 5));
                emit(addi(3, 0, 6));
                emit(beq(1, 2, 8));
                emit(sw(1, 10, 0));
                emit(bne(1, 2, 8));
                emit(sw(2, 10, 4));
                emit(beq(1, 3, 8));
                emit(sw(3, 10, 8));
                emit(bne(1, 3, 8));
                emit(sw(1, 10, 12));
                // countdown loop 3, 2, 1
                emit(addi(4, 0, 3));
                emit(sw(4, 10, 16));
                emit(addi(4, 4, -1));
                emit(bne(4, 0, -8));
                emit(addi(6, 0, 4));
                emit(addi(6, 6, 1));
                emit(sw(6, 10, 20));
                emit(beq(6, 2, -8));
            end
            3: begin
                emit(jal(1, 12));
                emit(sw(1, 10, 24));
                emit(sw(1, 10, 28));
                emit(sw(1, 10, 32));
                emit(jal(2, 8));
                emit(addi(3, 0, 1));
                emit(sw(2, 10, 36));
                emit(sw(3, 10, 40));
            end
            default: begin
                emit(addi(0, 0, 55));
                emit(lui(0, 'h12345));
                emit(add(0, 10, 10));
                emit(sw(0, 10, 44));
                emit(sw(10, 10, 48));
                emit(lw(0, 10, 48));
                emit(jal(0, 8));
                emit(addi(1, 0, 9));
                emit(add(1, 0, 0));
                emit(sw(0, 10, 52));
                emit(sw(1, 10, 56));
            end
        endcase
        emit(sw(0, 10, 'h3f0));
        emit(jal(0, 0));
    endtask

    task automatic run_test(input int id, input string name, input bit heavy);
        int steps;
        @(posedge inst_selfdefine);
        #1;
        reset     = 1'b1;
        running   = 1'b0;
        test_name = name;
        if (heavy) begin
            test_name = {name, " under stalls"};
        end
        stall_pct = heavy ? 75 : 20;
        max_delay = heavy ? 6 : 1;
        prog_len  = 0;
        fill_memory();
        write_program(id);
        steps     = reference_run();
        budget    = budget + steps * 40 + 20;
        got_count = 0;
        done_seen = 1'b0;
        repeat (8) @(posedge inst_selfdefine);
        #1;
        reset   = 1'b0;
        running = 1'b1;
        while (!done_seen) begin
            @(posedge inst_selfdefine);
        end
        repeat (4) @(posedge inst_selfdefine);
        running = 1'b0;
        if (got_count < exp_count) begin
            $display("%s: only %0d of %0d expected stores seen", test_name, got_count,
                     exp_count);
            error_count++;
        end
    endtask

    // store monitor on the external bus
    always @(negedge inst_selfdefine) begin
        if (running && !reset && mem_req_valid && mem_req_ready && mem_req.we) begin
            if (got_count < exp_count) begin
                compare_word($sformatf("%s store %0d address", test_name, got_count),
                             exp_addr[got_count], mem_req.addr);
                compare_word($sformatf("%s store %0d data", test_name, got_count),
                             exp_data[got_count], mem_req.wdata);
            end else begin
                $display("%s: unexpected extra store of %h to %h", test_name,
                         mem_req.wdata, mem_req.addr);
                error_count++;
            end
            got_count++;
            if (mem_req.addr == done_addr) begin
                done_seen = 1'b1;
            end
        end
    end

    initial begin
        cycles = 0;
        @(posedge inst_selfdefine);
        while (cycles <= budget) begin
            @(posedge inst_selfdefine);
            cycles++;
        end
        $display("watchdog expired after %0d cycles in test %s", cycles, test_name);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        running     = 1'b0;
        done_seen   = 1'b0;
        stall_pct   = 20;
        max_delay   = 1;
        error_count = 0;
        check_count = 0;
        got_count   = 0;
        exp_count   = 0;
        prog_len    = 0;
        budget      = 20;
        test_name   = "";
        run_test(0, "arith", 1'b0);
        run_test(1, "memory", 1'b0);
        run_test(2, "branch", 1'b0);
        run_test(3, "jal", 1'b0);
        run_test(4, "x0", 1'b0);
        // same programs with heavy back-pressure
        run_test(0, "arith", 1'b1);
        run_test(1, "memory", 1'b1);
        run_test(2, "branch", 1'b1);
        run_test(3, "jal", 1'b1);
        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
    input  logic                inst_selfdefine,
    input  logic                reset,

    input  logic                fetch_req_valid,
    output logic                fetch_req_ready,
    input  cpu_pkg::mem_req_t   fetch_req,
    output logic                fetch_rsp_valid,
    output cpu_pkg::mem_rsp_t   fetch_rsp,

    input  logic                lsu_req_valid,
    output logic                lsu_req_ready,
    input  cpu_pkg::mem_req_t   lsu_req,
    output logic                lsu_rsp_valid,
    output cpu_pkg::mem_rsp_t   lsu_rsp,

    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output cpu_pkg::mem_req_t   mem_req,
    input  logic                mem_rsp_valid,
    input  cpu_pkg::mem_rsp_t   mem_rsp
);

    logic busy;
    // owner of the outstanding transfer, high for lsu
    logic owner_lsu;

    assign mem_req_valid   = ~busy & (lsu_req_valid | fetch_req_valid);
    assign mem_req         = lsu_req_valid ? lsu_req : fetch_req;
    assign lsu_req_ready   = ~busy & mem_req_ready;
    assign fetch_req_ready = ~busy & mem_req_ready & ~lsu_req_valid;

    assign fetch_rsp_valid = mem_rsp_valid & busy & ~owner_lsu;
    assign lsu_rsp_valid   = mem_rsp_valid & busy & owner_lsu;
    assign fetch_rsp       = mem_rsp;
    assign lsu_rsp         = mem_rsp;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            busy      <= 1'b0;
            owner_lsu <= 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            busy      <= 1'b1;
            owner_lsu <= lsu_req_valid;
        end else if (busy && mem_rsp_valid) begin
            busy <= 1'b0;
        end
    end

endmodule

// File: hw/cpu_pkg.sv
package cpu_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 32;
    localparam int reg_idx_w = 5;

    localparam logic [xlen-1:0] pc_reset = 32'h0000_0000;

    // rv32 major opcodes of the kept subset
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_e;

    typedef enum logic [1:0] {
        alu_add,
        alu_sub,
        alu_pass
    } alu_op_e;

    typedef enum logic [1:0] {
        fetch_req,
        fetch_wait,
        execute
    } core_state_e;

    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            we;
    } mem_req_t;

    typedef struct packed {
        logic [xlen-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rd;
        logic                 reg_we;
        alu_op_e              alu_op;
        logic                 imm_src;
        logic                 load;
        logic                 store;
        logic                 branch;
        logic                 bne;
        logic                 jal;
        logic                 lui;
        logic [xlen-1:0]      imm;
    } decoded_t;

endpackage

// File: hw/cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
    input  logic                inst_selfdefine,
    input  logic                reset,
    output logic                mem_req_valid,
    input  logic                mem_req_ready,
    output cpu_pkg::mem_req_t   mem_req,
    input  logic                mem_rsp_valid,
    input  cpu_pkg::mem_rsp_t   mem_rsp
);

    // fetch side of the arbiter
    logic                       fetch_req_valid;
    logic                       fetch_req_ready;
    cpu_pkg::mem_req_t          fetch_req;
    logic                       fetch_rsp_valid;
    cpu_pkg::mem_rsp_t          fetch_rsp;

    // lsu side of the arbiter
    logic                       lsu_req_valid;
    logic                       lsu_req_ready;
    cpu_pkg::mem_req_t          lsu_req;
    logic                       lsu_rsp_valid;
    cpu_pkg::mem_rsp_t          lsu_rsp;

    logic [cpu_pkg::xlen-1:0]   pc;
    logic [cpu_pkg::xlen-1:0]   next_pc;
    logic [31:0]                inst;
    logic                       inst_valid;
    logic                       retire;
    cpu_pkg::decoded_t          dec;

    logic [cpu_pkg::xlen-1:0]   rs1_data;
    logic [cpu_pkg::xlen-1:0]   rs2_data;
    logic                       rd_we;
    logic [cpu_pkg::xlen-1:0]   rd_data;

    logic                       mem_start;
    logic [cpu_pkg::xlen-1:0]   mem_addr;
    logic [cpu_pkg::xlen-1:0]   store_data;
    logic                       lsu_done;
    logic [cpu_pkg::xlen-1:0]   load_data;

    fetch_unit u_fetch_unit (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .req_valid       (fetch_req_valid),
        .req_ready       (fetch_req_ready),
        .req             (fetch_req),
        .rsp_valid       (fetch_rsp_valid),
        .rsp             (fetch_rsp),
        .retire          (retire),
        .next_pc         (next_pc),
        .pc              (pc),
        .inst            (inst),
        .inst_valid      (inst_valid)
    );

    inst_decoder u_inst_decoder (
        .inst (inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .rs1_idx         (dec.rs1),
        .rs2_idx         (dec.rs2),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .we              (rd_we),
        .rd_idx          (dec.rd),
        .rd_data         (rd_data)
    );

    exec_unit u_exec_unit (
        .pc         (pc),
        .inst_valid (inst_valid),
        .dec        (dec),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .lsu_done   (lsu_done),
        .load_data  (load_data),
        .retire     (retire),
        .next_pc    (next_pc),
        .rd_we      (rd_we),
        .rd_data    (rd_data),
        .mem_start  (mem_start),
        .mem_addr   (mem_addr),
        .store_data (store_data)
    );

    lsu u_lsu (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .start           (mem_start),
        .addr            (mem_addr),
        .wdata           (store_data),
        .we              (dec.store),
        .req_valid       (lsu_req_valid),
        .req_ready       (lsu_req_ready),
        .req             (lsu_req),
        .rsp_valid       (lsu_rsp_valid),
        .rsp             (lsu_rsp),
        .done            (lsu_done),
        .load_data       (load_data)
    );

    bus_arbiter u_bus_arbiter (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req_ready (fetch_req_ready),
        .fetch_req       (fetch_req),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .lsu_req_valid   (lsu_req_valid),
        .lsu_req_ready   (lsu_req_ready),
        .lsu_req         (lsu_req),
        .lsu_rsp_valid   (lsu_rsp_valid),
        .lsu_rsp         (lsu_rsp),
        .mem_req_valid   (mem_req_valid),
        .mem_req_ready   (mem_req_ready),
        .mem_req         (mem_req),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp         (mem_rsp)
    );

endmodule

// File: hw/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic [cpu_pkg::xlen-1:0]    pc,
    input  logic                        inst_valid,
    input  cpu_pkg::decoded_t           dec,
    input  logic [cpu_pkg::xlen-1:0]    rs1_data,
    input  logic [cpu_pkg::xlen-1:0]    rs2_data,
    input  logic                        lsu_done,
    input  logic [cpu_pkg::xlen-1:0]    load_data,
    output logic                        retire,
    output logic [cpu_pkg::xlen-1:0]    next_pc,
    output logic                        rd_we,
    output logic [cpu_pkg::xlen-1:0]    rd_data,
    output logic                        mem_start,
    output logic [cpu_pkg::xlen-1:0]    mem_addr,
    output logic [cpu_pkg::xlen-1:0]    store_data
);

    logic [cpu_pkg::xlen-1:0] operand_b;
    logic [cpu_pkg::xlen-1:0] alu_res;
    logic [cpu_pkg::xlen-1:0] pc_plus4;
    logic                     rs_equal;
    logic                     taken;
    logic                     mem_op;

    assign operand_b = dec.imm_src ? dec.imm : rs2_data;

    always_comb begin
        case (dec.alu_op)
            cpu_pkg::alu_sub:  alu_res = rs1_data - operand_b;
            cpu_pkg::alu_pass: alu_res = operand_b;
            default:           alu_res = rs1_data + operand_b;
        endcase
    end

    assign rs_equal = (rs1_data == rs2_data);
    assign taken    = dec.jal | (dec.branch & (rs_equal ^ dec.bne));
    assign pc_plus4 = pc + 32'd4;
    assign next_pc  = taken ? pc + dec.imm : pc_plus4;

    assign mem_op = dec.load | dec.store;
    assign retire = inst_valid & (mem_op ? lsu_done : 1'b1);
    assign rd_we  = retire & dec.reg_we;

    assign rd_data = dec.jal  ? pc_plus4  :
                     dec.lui  ? dec.imm   :
                     dec.load ? load_data :
                                alu_res;

    // level request; lsu only takes it while idle, i.e. on the first execute cycle
    assign mem_start  = inst_valid & mem_op;
    assign mem_addr   = alu_res;
    assign store_data = rs2_data;

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                        inst_selfdefine,
    input  logic                        reset,
    output logic                        req_valid,
    input  logic                        req_ready,
    output cpu_pkg::mem_req_t           req,
    input  logic                        rsp_valid,
    input  cpu_pkg::mem_rsp_t           rsp,
    input  logic                        retire,
    input  logic [cpu_pkg::xlen-1:0]    next_pc,
    output logic [cpu_pkg::xlen-1:0]    pc,
    output logic [31:0]                 inst,
    output logic                        inst_valid
);

    cpu_pkg::core_state_e state;

    // fetches are read-only
    assign req = '{addr: pc, wdata: '0, we: 1'b0};

    assign inst_valid = (state == cpu_pkg::execute);

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state     <= cpu_pkg::fetch_req;
            req_valid <= 1'b0;
            pc        <= cpu_pkg::pc_reset;
        end else begin
            case (state)
                cpu_pkg::fetch_req: begin
                    if (!req_valid) begin
                        req_valid <= 1'b1;
                    end else if (req_ready) begin
                        req_valid <= 1'b0;
                        state     <= cpu_pkg::fetch_wait;
                    end
                end
                cpu_pkg::fetch_wait: begin
                    if (rsp_valid) begin
                        state <= cpu_pkg::execute;
                    end
                end
                default: begin
                    if (retire) begin
                        pc        <= next_pc;
                        req_valid <= 1'b1;
                        state     <= cpu_pkg::fetch_req;
                    end
                end
            endcase
        end
    end

    // instruction register, held until retire
    always_ff @(posedge inst_selfdefine) begin
        if (state == cpu_pkg::fetch_wait && rsp_valid) begin
            inst <= rsp.rdata;
        end
    end

endmodule

// File: hw/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  logic [31:0]         inst,
    output cpu_pkg::decoded_t   dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    logic [cpu_pkg::xlen-1:0] imm_i;
    logic [cpu_pkg::xlen-1:0] imm_s;
    logic [cpu_pkg::xlen-1:0] imm_b;
    logic [cpu_pkg::xlen-1:0] imm_u;
    logic [cpu_pkg::xlen-1:0] imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // anything not matched below stays a no-op
        dec     = '0;
        dec.rs1 = inst[19:15];
        dec.rs2 = inst[24:20];
        dec.rd  = inst[11:7];
        case (opcode)
            cpu_pkg::opc_op: begin
                if (funct3 == 3'b000 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)) begin
                    dec.reg_we = 1'b1;
                    dec.alu_op = funct7[5] ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
                end
            end
            cpu_pkg::opc_op_imm: begin
                if (funct3 == 3'b000) begin
                    dec.reg_we  = 1'b1;
                    dec.imm_src = 1'b1;
                    dec.imm     = imm_i;
                end
            end
            cpu_pkg::opc_lui: begin
                dec.reg_we  = 1'b1;
                dec.lui     = 1'b1;
                dec.alu_op  = cpu_pkg::alu_pass;
                dec.imm_src = 1'b1;
                dec.imm     = imm_u;
            end
            cpu_pkg::opc_load: begin
                if (funct3 == 3'b010) begin
                    dec.reg_we  = 1'b1;
                    dec.load    = 1'b1;
                    dec.imm_src = 1'b1;
                    dec.imm     = imm_i;
                end
            end
            cpu_pkg::opc_store: begin
                if (funct3 == 3'b010) begin
                    dec.store   = 1'b1;
                    dec.imm_src = 1'b1;
                    dec.imm     = imm_s;
                end
            end
            cpu_pkg::opc_branch: begin
                // beq and bne only
                if (funct3[2:1] == 2'b00) begin
                    dec.branch = 1'b1;
                    dec.bne    = funct3[0];
                    dec.imm    = imm_b;
                end
            end
            cpu_pkg::opc_jal: begin
                dec.reg_we = 1'b1;
                dec.jal    = 1'b1;
                dec.imm    = imm_j;
            end
            default: begin
                dec.reg_we = 1'b0;
            end
        endcase
    end

endmodule

// File: hw/lsu.sv
`timescale 1ns/1ns

module lsu (
    input  logic                        inst_selfdefine,
    input  logic                        reset,
    input  logic                        start,
    input  logic [cpu_pkg::xlen-1:0]    addr,
    input  logic [cpu_pkg::xlen-1:0]    wdata,
    input  logic                        we,
    output logic                        req_valid,
    input  logic                        req_ready,
    output cpu_pkg::mem_req_t           req,
    input  logic                        rsp_valid,
    input  cpu_pkg::mem_rsp_t           rsp,
    output logic                        done,
    output logic [cpu_pkg::xlen-1:0]    load_data
);

    typedef enum logic [1:0] {
        lsu_idle,
        lsu_hold,
        lsu_wait
    } lsu_state_e;

    lsu_state_e state;

    // operands stay stable while the instruction is held
    assign req       = '{addr: addr, wdata: wdata, we: we};
    assign req_valid = (state == lsu_idle && start) || (state == lsu_hold);
    assign done      = (state == lsu_wait) && rsp_valid;
    assign load_data = rsp.rdata;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state <= lsu_idle;
        end else begin
            case (state)
                lsu_idle: begin
                    if (start) begin
                        state <= req_ready ? lsu_wait : lsu_hold;
                    end
                end
                lsu_hold: begin
                    if (req_ready) begin
                        state <= lsu_wait;
                    end
                end
                default: begin
                    if (rsp_valid) begin
                        state <= lsu_idle;
                    end
                end
            endcase
        end
    end

endmodule

// File: hw/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                            inst_selfdefine,
    input  logic                            reset,
    input  logic [cpu_pkg::reg_idx_w-1:0]   rs1_idx,
    input  logic [cpu_pkg::reg_idx_w-1:0]   rs2_idx,
    output logic [cpu_pkg::xlen-1:0]        rs1_data,
    output logic [cpu_pkg::xlen-1:0]        rs2_data,
    input  logic                            we,
    input  logic [cpu_pkg::reg_idx_w-1:0]   rd_idx,
    input  logic [cpu_pkg::xlen-1:0]        rd_data
);

    logic [cpu_pkg::xlen-1:0] regs [cpu_pkg::reg_count];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 0; i < cpu_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_idx != '0) begin
            regs[rd_idx] <= rd_data;
        end
    end

    // x0 is never written, so it reads zero
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

endmodule
